//--- hw/tdc_defs.svh
`ifndef TDC_DEFS_SVH
`define TDC_DEFS_SVH

// Cycles between two start pulses
`define SHOOT_PERIOD 64

// Cycles to wait for the TDC interrupt before the shot is dropped
`define HIT_TIMEOUT 40

// Cycles per half SPI clock period
`define SPI_HALF_DIV 2

// Cycles per UART bit
`define BAUD_DIV 8

// Sample FIFO holds 2**FIFO_DEPTH_LOG2 entries
`define FIFO_DEPTH_LOG2 2

// Width of one TDC result, two SPI bytes
`define RESULT_WIDTH 16

`endif

//--- hw/tdc_pkg.sv
`include "tdc_defs.svh"

package tdc_pkg;

  // One measured time of flight
  typedef logic [`RESULT_WIDTH-1:0] tdc_result_t;

  // Measurement sequence of one channel
  typedef enum logic [2:0] {
    IDLE,
    FIRE,
    WAIT_HIT,
    SEND_OP,
    READ_HI,
    READ_LO,
    PUSH
  } tdc_state_t;

  // TDC SPI opcodes
  typedef enum logic [7:0] {
    OP_READ_RESULT = 8'h08
  } tdc_opcode_t;

  // Serial transmitter states
  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP
  } uart_state_t;

endpackage

//--- hw/tdc_spi_if.sv
interface tdc_spi_if;

  // Byte request from the controller, four-phase req/ack
  logic       req;
  logic [7:0] tx_byte;
  logic       last;

  // Byte completion from the master
  logic       ack;
  logic [7:0] rx_byte;

  modport ctrl (
    output req, tx_byte, last,
    input  ack, rx_byte
  );

  modport master (
    input  req, tx_byte, last,
    output ack, rx_byte
  );

endinterface

//--- hw/tdc_spi_master.sv
`include "tdc_defs.svh"

module tdc_spi_master (
  input  logic      clk,
  input  logic      reset,
  tdc_spi_if.master bus,
  input  logic      dout,
  output logic      mosi,
  output logic      sck,
  output logic      cs
);
  localparam int DIV_W = $clog2(`SPI_HALF_DIV + 1);

  logic             busy;
  logic             ack_q;
  logic             last_q;
  logic [DIV_W-1:0] div_cnt;
  logic [3:0]       edge_cnt;
  logic [7:0]       tx_shift;
  logic [7:0]       rx_shift;

  assign bus.ack     = ack_q;
  assign bus.rx_byte = rx_shift;
  // MSB first, updated on the falling sck edge
  assign mosi        = tx_shift[7];

  always_ff @(posedge clk) begin
    if (reset) begin
      busy     <= 1'b0;
      ack_q    <= 1'b0;
      cs       <= 1'b1;
      sck      <= 1'b0;
      div_cnt  <= '0;
      edge_cnt <= '0;
      tx_shift <= '0;
    end else if (!busy) begin
      if (bus.req && !ack_q) begin
        // New byte, chip select stays low until a last byte ends
        busy     <= 1'b1;
        cs       <= 1'b0;
        tx_shift <= bus.tx_byte;
        div_cnt  <= '0;
        edge_cnt <= '0;
      end else if (!bus.req && ack_q) begin
        ack_q <= 1'b0;
      end
    end else if (div_cnt == DIV_W'(`SPI_HALF_DIV - 1)) begin
      div_cnt  <= '0;
      sck      <= ~sck;
      edge_cnt <= edge_cnt + 1'b1;
      if (!sck) begin
        rx_shift <= {rx_shift[6:0], dout};
      end else begin
        tx_shift <= {tx_shift[6:0], 1'b0};
      end
      // Sixteen half periods per byte
      if (edge_cnt == 4'd15) begin
        busy  <= 1'b0;
        ack_q <= 1'b1;
        if (last_q) begin
          cs <= 1'b1;
        end
      end
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!busy && bus.req && !ack_q) begin
      last_q <= bus.last;
    end
  end

  // Controller must hold req until the byte is done
  a_ack_needs_req: assert property (
    @(posedge clk) disable iff (reset) $rose(bus.ack) |-> bus.req
  ) else $error("SPI ack raised without a pending req");

endmodule

//--- hw/tdc_control.sv
`include "tdc_defs.svh"

module tdc_control (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 pause,
  input  logic                 intb,
  output logic                 start_signal,
  tdc_spi_if.ctrl              spi,
  output logic                 sample_req,
  input  logic                 sample_ack,
  output tdc_pkg::tdc_result_t sample_data
);
  import tdc_pkg::*;

  localparam int SHOT_W = $clog2(`SHOOT_PERIOD + 1);
  localparam int HIT_W  = $clog2(`HIT_TIMEOUT + 1);

  tdc_state_t        state;
  tdc_state_t        next_step;
  logic [SHOT_W-1:0] shot_cnt;
  logic [HIT_W-1:0]  hit_cnt;
  logic              spi_req;
  logic              hs_done;
  logic [7:0]        hi_byte;
  tdc_result_t       result_q;

  // Step that follows each SPI byte
  always_comb begin
    case (state)
      SEND_OP: next_step = READ_HI;
      READ_HI: next_step = READ_LO;
      default: next_step = PUSH;
    endcase
  end

  assign spi.req     = spi_req;
  assign spi.tx_byte = (state == SEND_OP) ? OP_READ_RESULT : 8'h00;
  assign spi.last    = (state == READ_LO);
  assign sample_data = result_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      state        <= IDLE;
      shot_cnt     <= '0;
      hit_cnt      <= '0;
      spi_req      <= 1'b0;
      hs_done      <= 1'b0;
      sample_req   <= 1'b0;
      start_signal <= 1'b0;
    end else begin
      start_signal <= 1'b0;
      // Shot timer runs down from the last pulse
      if (shot_cnt != '0) begin
        shot_cnt <= shot_cnt - 1'b1;
      end
      case (state)
        IDLE: begin
          if (shot_cnt == '0 && !pause) begin
            start_signal <= 1'b1;
            shot_cnt     <= SHOT_W'(`SHOOT_PERIOD - 1);
            state        <= FIRE;
          end
        end
        FIRE: begin
          hit_cnt <= '0;
          state   <= WAIT_HIT;
        end
        WAIT_HIT: begin
          if (!intb) begin
            state <= SEND_OP;
          end else if (hit_cnt == HIT_W'(`HIT_TIMEOUT - 1)) begin
            state <= IDLE;  // no echo, nothing stored
          end else begin
            hit_cnt <= hit_cnt + 1'b1;
          end
        end
        SEND_OP, READ_HI, READ_LO: begin
          if (!spi_req && !hs_done && !spi.ack) begin
            spi_req <= 1'b1;
          end else if (spi_req && spi.ack) begin
            spi_req <= 1'b0;
            hs_done <= 1'b1;
          end else if (hs_done && !spi.ack) begin
            hs_done <= 1'b0;
            state   <= next_step;
          end
        end
        PUSH: begin
          // Stays here while the FIFO is full
          if (!sample_req && !hs_done && !sample_ack) begin
            sample_req <= 1'b1;
          end else if (sample_req && sample_ack) begin
            sample_req <= 1'b0;
            hs_done    <= 1'b1;
          end else if (hs_done && !sample_ack) begin
            hs_done <= 1'b0;
            state   <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Result bytes from the SPI master
  always_ff @(posedge clk) begin
    if (spi_req && spi.ack && state == READ_HI) begin
      hi_byte <= spi.rx_byte;
    end
    if (spi_req && spi.ack && state == READ_LO) begin
      result_q <= {hi_byte, spi.rx_byte};
    end
  end

  a_start_one_cycle: assert property (
    @(posedge clk) disable iff (reset) start_signal |=> !start_signal
  ) else $error("Start pulse longer than one cycle");

endmodule

//--- hw/sample_fifo.sv
`include "tdc_defs.svh"

module sample_fifo (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 in_req,
  output logic                 in_ack,
  input  tdc_pkg::tdc_result_t in_data,
  output logic                 out_req,
  input  logic                 out_ack,
  output tdc_pkg::tdc_result_t out_data
);
  import tdc_pkg::*;

  localparam int AW = `FIFO_DEPTH_LOG2;

  tdc_result_t mem [2**AW];
  // Extra MSB tells full from empty
  logic [AW:0] wr_ptr;
  logic [AW:0] rd_ptr;
  logic        full;
  logic        empty;
  logic        wr_en;
  logic        rd_en;

  assign empty    = (wr_ptr == rd_ptr);
  assign full     = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
  assign wr_en    = in_req && !in_ack && !full;
  assign rd_en    = out_req && out_ack;
  assign out_data = mem[rd_ptr[AW-1:0]];

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      in_ack  <= 1'b0;
      out_req <= 1'b0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
        in_ack <= 1'b1;
      end else if (in_ack && !in_req) begin
        in_ack <= 1'b0;
      end
      // Pop on ack, next word only after ack is back low
      if (rd_en) begin
        rd_ptr  <= rd_ptr + 1'b1;
        out_req <= 1'b0;
      end else if (!out_req && !out_ack && !empty) begin
        out_req <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr[AW-1:0]] <= in_data;
    end
  end

  // Occupancy never exceeds the depth
  a_no_write_full: assert property (
    @(posedge clk) disable iff (reset) (wr_ptr - rd_ptr) <= (AW+1)'(2**AW)
  ) else $error("Sample written into a full FIFO");

endmodule

//--- hw/uart_tx.sv
`include "tdc_defs.svh"

module uart_tx (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 req,
  output logic                 ack,
  input  tdc_pkg::tdc_result_t data,
  output logic                 serial_out
);
  import tdc_pkg::*;

  localparam int BAUD_W = $clog2(`BAUD_DIV + 1);

  uart_state_t       state;
  logic [BAUD_W-1:0] baud_cnt;
  logic              baud_tick;
  logic              latch;
  logic [2:0]        bit_idx;
  logic              second;
  logic [7:0]        shift_q;
  logic [7:0]        lo_byte;

  assign baud_tick = (baud_cnt == BAUD_W'(`BAUD_DIV - 1));
  assign latch     = (state == TX_IDLE) && req && !ack;

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= TX_IDLE;
      baud_cnt   <= '0;
      bit_idx    <= '0;
      second     <= 1'b0;
      ack        <= 1'b0;
      serial_out <= 1'b1;
    end else begin
      if (state == TX_IDLE || baud_tick) begin
        baud_cnt <= '0;
      end else begin
        baud_cnt <= baud_cnt + 1'b1;
      end
      if (ack && !req) begin
        ack <= 1'b0;
      end
      case (state)
        TX_IDLE: begin
          if (latch) begin
            ack        <= 1'b1;
            second     <= 1'b0;
            serial_out <= 1'b0;
            state      <= TX_START;
          end
        end
        TX_START: begin
          if (baud_tick) begin
            serial_out <= shift_q[0];
            bit_idx    <= '0;
            state      <= TX_DATA;
          end
        end
        TX_DATA: begin
          if (baud_tick) begin
            if (bit_idx == 3'd7) begin
              serial_out <= 1'b1;
              state      <= TX_STOP;
            end else begin
              serial_out <= shift_q[0];
              bit_idx    <= bit_idx + 1'b1;
            end
          end
        end
        TX_STOP: begin
          if (baud_tick) begin
            // High byte done, low byte follows
            if (!second) begin
              second     <= 1'b1;
              serial_out <= 1'b0;
              state      <= TX_START;
            end else begin
              state <= TX_IDLE;
            end
          end
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

  // LSB first shift register
  always_ff @(posedge clk) begin
    if (latch) begin
      shift_q <= data[15:8];
      lo_byte <= data[7:0];
    end else if (state == TX_STOP && baud_tick && !second) begin
      shift_q <= lo_byte;
    end else if (baud_tick && (state == TX_START || state == TX_DATA)) begin
      shift_q <= {1'b0, shift_q[7:1]};
    end
  end

endmodule

//--- hw/ranging_top.sv
module ranging_top (
  input  logic clk,
  input  logic reset,
  input  logic pause,
  input  logic tdc_intb,
  input  logic tdc_dout,
  output logic tdc_mosi,
  output logic tdc_sck,
  output logic tdc_cs,
  output logic tdc_start_signal,
  output logic serial_out
);
  import tdc_pkg::*;

  // Sample link and FIFO to UART link
  logic        sample_req;
  logic        sample_ack;
  tdc_result_t sample_data;
  logic        out_req;
  logic        out_ack;
  tdc_result_t out_data;

  tdc_spi_if spi_bus ();

  tdc_control i_control (
    .clk          (clk),
    .reset        (reset),
    .pause        (pause),
    .intb         (tdc_intb),
    .start_signal (tdc_start_signal),
    .spi          (spi_bus.ctrl),
    .sample_req   (sample_req),
    .sample_ack   (sample_ack),
    .sample_data  (sample_data)
  );

  tdc_spi_master i_spi_master (
    .clk   (clk),
    .reset (reset),
    .bus   (spi_bus.master),
    .dout  (tdc_dout),
    .mosi  (tdc_mosi),
    .sck   (tdc_sck),
    .cs    (tdc_cs)
  );

  sample_fifo i_fifo (
    .clk      (clk),
    .reset    (reset),
    .in_req   (sample_req),
    .in_ack   (sample_ack),
    .in_data  (sample_data),
    .out_req  (out_req),
    .out_ack  (out_ack),
    .out_data (out_data)
  );

  uart_tx i_uart (
    .clk        (clk),
    .reset      (reset),
    .req        (out_req),
    .ack        (out_ack),
    .data       (out_data),
    .serial_out (serial_out)
  );

endmodule

//--- dv/ranging_tb.sv
`include "tdc_defs.svh"

module ranging_tb;
  import tdc_pkg::*;

  localparam int START_LIMIT = 3000;
  localparam int CS_LIMIT    = 300;
  localparam int DRAIN_LIMIT = 60000;
  localparam int PAUSE_LEN   = 300;

  logic clk;
  logic reset;
  logic pause;
  logic tdc_intb;
  logic tdc_dout;
  logic tdc_mosi;
  logic tdc_sck;
  logic tdc_cs;
  logic tdc_start_signal;
  logic serial_out;

  int          seed;
  int          errors;
  int          timeouts;
  int          line_pause[$];
  int          line_delay[$];
  logic [15:0] line_result[$];
  logic [15:0] expected[$];
  logic [15:0] cur_result;
  int          rx_count;
  int          pulse_count;

  ranging_top i_dut (
    .clk              (clk),
    .reset            (reset),
    .pause            (pause),
    .tdc_intb         (tdc_intb),
    .tdc_dout         (tdc_dout),
    .tdc_mosi         (tdc_mosi),
    .tdc_sck          (tdc_sck),
    .tdc_cs           (tdc_cs),
    .tdc_start_signal (tdc_start_signal),
    .serial_out       (serial_out)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  // Start pulse monitor: width, spacing and pause
  longint cycle;
  longint last_pulse;
  logic   have_pulse;
  logic   start_prev;
  logic   pause_q;

  initial begin
    cycle      = 0;
    last_pulse = 0;
    have_pulse = 1'b0;
    start_prev = 1'b0;
    pause_q    = 1'b0;
  end

  always @(posedge clk) pause_q <= pause;

  always @(negedge clk) begin
    cycle = cycle + 1;
    if (!reset && tdc_start_signal) begin
      assert (!start_prev) else begin
        errors++;
        $display("** Error at time %0t: start pulse longer than one cycle", $time);
      end
      assert (!pause_q) else begin
        errors++;
        $display("** Error at time %0t: start pulse while pause is high", $time);
      end
      if (have_pulse && !start_prev) begin
        assert (cycle - last_pulse >= `SHOOT_PERIOD) else begin
          errors++;
          $display("** Error at time %0t: pulses only %0d cycles apart", $time,
                   cycle - last_pulse);
        end
      end
      if (!start_prev) begin
        pulse_count++;
      end
      last_pulse = cycle;
      have_pulse = 1'b1;
    end
    start_prev = tdc_start_signal;
  end

  // TDC model SPI side: result out on dout, opcode in on mosi
  logic        cs_prev;
  logic        sck_prev;
  int          bit_cnt;
  logic [23:0] frame;
  logic [7:0]  mosi_byte;

  initial begin
    cs_prev  = 1'b1;
    sck_prev = 1'b0;
    bit_cnt  = 0;
  end

  always @(negedge clk) begin
    if (!tdc_cs && cs_prev) begin
      bit_cnt  = 0;
      frame    = {8'h00, cur_result};
      tdc_dout = frame[23];
    end else if (!tdc_cs) begin
      if (tdc_sck && !sck_prev) begin
        mosi_byte = {mosi_byte[6:0], tdc_mosi};
        bit_cnt++;
        if (bit_cnt == 8) begin
          assert (mosi_byte == OP_READ_RESULT) else begin
            errors++;
            $display("** Error at time %0t: SPI opcode %02h, expected %02h", $time,
                     mosi_byte, OP_READ_RESULT);
          end
        end
      end
      if (!tdc_sck && sck_prev && bit_cnt < 24) begin
        tdc_dout = frame[23 - bit_cnt];
      end
    end
    cs_prev  = tdc_cs;
    sck_prev = tdc_sck;
  end

  // UART receiver, 8N1, samples near the bit centers
  logic        rx_busy;
  int          rx_cnt;
  logic [7:0]  rx_byte;
  logic [7:0]  rx_hi;
  logic        rx_have_hi;
  logic [15:0] rx_word;

  initial begin
    rx_busy    = 1'b0;
    rx_cnt     = 0;
    rx_have_hi = 1'b0;
    rx_count   = 0;
  end

  always @(negedge clk) begin
    if (reset) begin
      rx_busy = 1'b0;
    end else if (!rx_busy) begin
      if (!serial_out) begin
        rx_busy = 1'b1;
        rx_cnt  = 0;
      end
    end else begin
      rx_cnt++;
      if (rx_cnt > `BAUD_DIV / 2 && rx_cnt < `BAUD_DIV * 9 + `BAUD_DIV / 2 &&
          (rx_cnt - `BAUD_DIV / 2) % `BAUD_DIV == 0) begin
        rx_byte = {serial_out, rx_byte[7:1]};
      end
      if (rx_cnt == `BAUD_DIV * 9 + `BAUD_DIV / 2) begin
        rx_busy = 1'b0;
        assert (serial_out) else begin
          errors++;
          $display("** Error at time %0t: UART stop bit low", $time);
        end
        if (!rx_have_hi) begin
          rx_hi      = rx_byte;
          rx_have_hi = 1'b1;
        end else begin
          rx_have_hi = 1'b0;
          rx_word    = {rx_hi, rx_byte};
          rx_count++;
          if (expected.size() == 0) begin
            errors++;
            $display("Received word %04h with no shot left to expect", rx_word);
          end else begin
            assert (rx_word == expected[0]) else begin
              errors++;
              $display("** Error at time %0t: word %04h, expected %04h", $time,
                       rx_word, expected[0]);
            end
            void'(expected.pop_front());
          end
        end
      end
    end
  end

  task automatic wait_start(output logic ok);
    int n;
    ok = 1'b0;
    n  = 0;
    while (!ok && n < START_LIMIT) begin
      @(negedge clk);
      n++;
      ok = tdc_start_signal;
    end
  endtask

  task automatic wait_cs(input logic level, output logic ok);
    int n;
    ok = 1'b0;
    n  = 0;
    while (!ok && n < CS_LIMIT) begin
      @(negedge clk);
      n++;
      ok = (tdc_cs == level);
    end
  endtask

  task automatic load_tests();
    int    fd;
    int    code;
    int    p;
    int    d;
    int    r;
    string line;
    fd = $fopen("dv/ranging_tests.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Could not open dv/ranging_tests.txt");
    end else begin
      while (!$feof(fd)) begin
        code = $fgets(line, fd);
        if (code > 0 && $sscanf(line, "%d %d %h", p, d, r) == 3) begin
          // Random hit delay inside the timeout window
          if (d == 99) begin
            d = 5 + ({$random(seed)} % 25);
          end
          line_pause.push_back(p);
          line_delay.push_back(d);
          line_result.push_back(r[15:0]);
          if (d != 0) begin
            expected.push_back(r[15:0]);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  initial begin
    logic ok;
    int   n;
    int   hits;
    seed        = 72085;
    errors      = 0;
    timeouts    = 0;
    pulse_count = 0;
    hits        = 0;
    reset       = 1'b1;
    pause       = 1'b0;
    tdc_intb    = 1'b1;
    tdc_dout    = 1'b0;
    cur_result  = '0;
    ok          = 1'b1;
    load_tests();
    repeat (10) @(negedge clk);
    assert (tdc_cs && !tdc_sck && serial_out && !tdc_start_signal) else begin
      errors++;
      $display("** Error at time %0t: wrong output levels in reset", $time);
    end
    reset = 1'b0;

    for (int i = 0; i < line_delay.size() && ok; i++) begin
      if (line_pause[i] != 0) begin
        pause = 1'b1;
        repeat (PAUSE_LEN) @(negedge clk);
        pause = 1'b0;
      end
      cur_result = line_result[i];
      wait_start(ok);
      if (!ok) begin
        timeouts++;
        $display("Timed out waiting for the start pulse of shot %0d", i);
      end else if (line_delay[i] != 0) begin
        hits++;
        repeat (line_delay[i]) @(negedge clk);
        tdc_intb = 1'b0;
        wait_cs(1'b0, ok);
        tdc_intb = 1'b1;
        if (ok) begin
          wait_cs(1'b1, ok);
        end
        if (!ok) begin
          timeouts++;
          $display("Timed out waiting for the SPI frame of shot %0d", i);
        end
      end
    end

    // No further shots while the FIFO drains
    pause = 1'b1;

    if (ok) begin
      n = 0;
      while (rx_count < hits && n < DRAIN_LIMIT) begin
        @(negedge clk);
        n++;
      end
      if (rx_count < hits) begin
        timeouts++;
        $display("Timed out with %0d of %0d words received", rx_count, hits);
      end
      assert (pulse_count == line_delay.size()) else begin
        errors++;
        $display("** Error at time %0t: %0d start pulses, expected %0d", $time,
                 pulse_count, line_delay.size());
      end
    end

    $display("Check errors: %0d, timeouts: %0d, words received: %0d",
             errors, timeouts, rx_count);
    if (errors == 0 && timeouts == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

//--- filelist.f
+incdir+hw
hw/tdc_pkg.sv
hw/tdc_spi_if.sv
hw/tdc_spi_master.sv
hw/tdc_control.sv
hw/sample_fifo.sv
hw/uart_tx.sv
hw/ranging_top.sv
dv/ranging_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the ranging channel testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
  --top-module ranging_tb \
  -f filelist.f \
  -o ranging_sim

./obj_dir/ranging_sim | tee sim.log

if grep -q "Verification passed" sim.log; then
  exit 0
else
  exit 1
fi

//--- dv/ranging_tests.txt
# pause hit_delay result_hex, one shot per line
# hit_delay 0 means no hit, 99 picks a random delay
0 5 1234
0 12 abcd
0 0 dead
0 7 0f0f
1 9 8001
0 99 55aa
0 3 00ff
0 3 ff00
0 3 1357
0 3 2468
0 3 9abc
0 3 def0
0 0 beef
1 4 7e81
0 3 a5a5
0 3 3c3c
0 3 c3c3
0 99 0001
